//--- Bender.yml
package:
  name: scene_render

sources:
  - files:
      - source/scene_pkg.sv
      - source/rect_scanner.sv
      - source/missile_tracer.sv
      - source/pixel_credit_out.sv
      - source/render_ctrl.sv
      - source/scene_render_top.sv
  - target: simulation
    files:
      - tb/scene_render_sva.sv
      - tb/tb_scene_render.sv

//--- scene_render.f
source/scene_pkg.sv
source/rect_scanner.sv
source/missile_tracer.sv
source/pixel_credit_out.sv
source/render_ctrl.sv
source/scene_render_top.sv
tb/scene_render_sva.sv
tb/tb_scene_render.sv

//--- source/missile_tracer.sv
`timescale 1ns/10ps

module missile_tracer
	import scene_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  missile_idx_t missile_idx,
	input  logic         missile_go,
	input  logic         take,
	output pixel_t       pixel,
	output logic         pixel_valid,
	output logic         trail_last
);

	coord_t cx;
	coord_t cy;
	step_t dx;
	coord_t next_y;
	logic active;
	logic last_point;

	assign next_y = cy + coord_t'(MISSILE_DY);
	// Next step would reach the city row
	assign last_point = (next_y >= coord_t'(MISSILE_Y_END));

	// Step along the trail
	// ------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cx <= '0;
			cy <= '0;
			dx <= '0;
			active <= 1'b0;
		end
		else if (missile_go)
		begin
			cx <= MISSILE_TABLE[missile_idx].x0;
			dx <= MISSILE_TABLE[missile_idx].dx;
			cy <= '0;
			active <= 1'b1;
		end
		else if (take && active)
		begin
			// dx is two's complement, sign extended to coordinate width
			cx <= cx + {{(COORD_W-4){dx[3]}}, dx};
			cy <= next_y;
			if (last_point)
				active <= 1'b0;
		end
	end

	assign pixel.x = cx;
	assign pixel.y = cy;
	assign pixel.color = COLOR_MISSILE;
	assign pixel_valid = active;
	assign trail_last = take && active && last_point;

endmodule

//--- source/pixel_credit_out.sv
`timescale 1ns/10ps

module pixel_credit_out
	import scene_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  src_sel_t src_sel,
	input  pixel_t   rect_pixel,
	input  logic     rect_valid,
	input  pixel_t   trail_pixel,
	input  logic     trail_valid,
	input  logic     credit_return,
	output logic     take,
	output pixel_t   pix,
	output logic     pix_valid
);

	credit_t credit;
	pixel_t sel_pixel;
	logic sel_valid;

	always_comb
	begin
		case (src_sel)
			SRC_RECT:
			begin
				sel_pixel = rect_pixel;
				sel_valid = rect_valid;
			end
			SRC_MISSILE:
			begin
				sel_pixel = trail_pixel;
				sel_valid = trail_valid;
			end
			default:
			begin
				sel_pixel = rect_pixel;
				sel_valid = 1'b0;
			end
		endcase
	end

	// The pixel now on the output still owns one credit
	assign take = sel_valid && (credit > credit_t'(pix_valid));

	always_ff @(posedge clk)
	begin
		if (take)
			pix <= sel_pixel;
	end

	// Credit count and output valid
	// ------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			credit <= credit_t'(PIX_CREDITS);
			pix_valid <= 1'b0;
		end
		else
		begin
			credit <= credit - credit_t'(pix_valid) + credit_t'(credit_return);
			pix_valid <= take;
		end
	end

endmodule

//--- source/rect_scanner.sv
`timescale 1ns/10ps

module rect_scanner
	import scene_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  rect_idx_t rect_idx,
	input  logic      rect_go,
	input  logic      take,
	output pixel_t    pixel,
	output logic      pixel_valid,
	output logic      rect_last
);

	rect_t cur;
	coord_t cx;
	coord_t cy;
	logic active;
	logic row_end;
	logic col_end;

	// Latched table entry
	always_ff @(posedge clk)
	begin
		if (rect_go)
			cur <= RECT_TABLE[rect_idx];
	end

	assign row_end = (cx == cur.width - 9'd1);
	assign col_end = (cy == cur.height - 9'd1);

	// Raster counters, x fastest
	// ------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cx <= '0;
			cy <= '0;
			active <= 1'b0;
		end
		else if (rect_go)
		begin
			cx <= '0;
			cy <= '0;
			active <= 1'b1;
		end
		else if (take && active)
		begin
			if (row_end)
			begin
				cx <= '0;
				if (col_end)
					active <= 1'b0;
				else
					cy <= cy + 9'd1;
			end
			else
			begin
				cx <= cx + 9'd1;
			end
		end
	end

	assign pixel.x = cur.x0 + cx;
	assign pixel.y = cur.y0 + cy;
	assign pixel.color = cur.color;
	assign pixel_valid = active;
	assign rect_last = take && active && row_end && col_end;

endmodule

//--- source/render_ctrl.sv
`timescale 1ns/10ps

module render_ctrl
	import scene_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic [NUM_MISSILES-1:0] missile_en,
	input  logic                    rect_last,
	input  logic                    trail_last,
	output rect_idx_t               rect_idx,
	output logic                    rect_go,
	output missile_idx_t            missile_idx,
	output logic                    missile_go,
	output src_sel_t                src_sel,
	output logic                    busy,
	output logic                    done
);

	ctrl_state_t state;

	// Missiles still waiting to be drawn in this frame
	logic [NUM_MISSILES-1:0] pending;
	missile_idx_t next_idx;
	logic next_found;

	// Lowest pending missile wins
	always_comb
	begin
		next_idx = '0;
		next_found = 1'b0;
		for (int i = NUM_MISSILES - 1; i >= 0; i--)
		begin
			if (pending[i])
			begin
				next_idx = missile_idx_t'(i);
				next_found = 1'b1;
			end
		end
	end

	// Sequencer
	// ------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= IDLE;
			pending <= '0;
			rect_idx <= '0;
			rect_go <= 1'b0;
			missile_idx <= '0;
			missile_go <= 1'b0;
		end
		else
		begin
			rect_go <= 1'b0;
			missile_go <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						pending <= missile_en;
						rect_idx <= '0;
						rect_go <= 1'b1;
						state <= RECT_RUN;
					end
				end
				RECT_RUN:
				begin
					if (rect_last)
					begin
						if (rect_idx == rect_idx_t'(NUM_RECTS - 1))
						begin
							state <= MISSILE_NEXT;
						end
						else
						begin
							rect_idx <= rect_idx + 3'd1;
							rect_go <= 1'b1;
						end
					end
				end
				MISSILE_NEXT:
				begin
					if (next_found)
					begin
						missile_idx <= next_idx;
						pending[next_idx] <= 1'b0;
						missile_go <= 1'b1;
						state <= MISSILE_RUN;
					end
					else
					begin
						state <= FINISH;
					end
				end
				MISSILE_RUN:
				begin
					if (trail_last)
						state <= MISSILE_NEXT;
				end
				FINISH:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Output decode
	always_comb
	begin
		case (state)
			RECT_RUN:    src_sel = SRC_RECT;
			MISSILE_RUN: src_sel = SRC_MISSILE;
			default:     src_sel = SRC_NONE;
		endcase
	end

	// Done lands one cycle after the last pixel leaves the output register
	assign done = (state == FINISH);
	assign busy = (state != IDLE) && (state != FINISH);

endmodule

//--- source/scene_pkg.sv
package scene_pkg;

	// Widths and plain vector types
	// ------------------------------
	localparam int COORD_W = 9;
	localparam int COLOR_W = 3;

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [COLOR_W-1:0] color_t;
	typedef logic signed [3:0] step_t;

	// Screen and colour codes
	// ------------------------------
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;
	localparam int GROUND_Y = 210;

	localparam color_t COLOR_BACK    = 3'd0;
	localparam color_t COLOR_GROUND  = 3'd7;
	localparam color_t COLOR_CITY    = 3'd2;
	localparam color_t COLOR_MISSILE = 3'd5;

	// Filled rectangles, painted in table order
	// ------------------------------
	typedef struct packed {
		coord_t x0;
		coord_t y0;
		coord_t width;
		coord_t height;
		color_t color;
	} rect_t;

	localparam int NUM_RECTS = 7;
	typedef logic [2:0] rect_idx_t;

	localparam rect_t RECT_TABLE [NUM_RECTS] = '{
		'{9'd0, 9'd0, 9'(SCREEN_W), 9'(SCREEN_H), COLOR_BACK},
		'{9'd0, 9'(GROUND_Y), 9'(SCREEN_W), 9'(SCREEN_H - GROUND_Y), COLOR_GROUND},
		'{9'd152, 9'd200, 9'd16, 9'd10, COLOR_CITY},
		'{9'd78, 9'd203, 9'd7, 9'd2, COLOR_CITY},
		'{9'd75, 9'd205, 9'd10, 9'd5, COLOR_CITY},
		'{9'd238, 9'd203, 9'd7, 9'd2, COLOR_CITY},
		'{9'd235, 9'd205, 9'd10, 9'd5, COLOR_CITY}
	};

	// Enemy missiles, all starting at row 0
	// ------------------------------
	typedef struct packed {
		coord_t x0;
		step_t dx;
	} missile_t;

	localparam int NUM_MISSILES = 4;
	typedef logic [1:0] missile_idx_t;

	localparam missile_t MISSILE_TABLE [NUM_MISSILES] = '{
		'{9'd54, 4'sd1},
		'{9'd128, -4'sd2},
		'{9'd56, 4'sd4},
		'{9'd266, -4'sd1}
	};

	localparam int MISSILE_DY    = 8;
	localparam int MISSILE_Y_END = 206;

	// Output record and credits
	typedef struct packed {
		coord_t x;
		coord_t y;
		color_t color;
	} pixel_t;

	localparam int PIX_CREDITS = 4;
	typedef logic [2:0] credit_t;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_RECT,
		SRC_MISSILE
	} src_sel_t;

	typedef enum logic [2:0] {
		IDLE,
		RECT_RUN,
		MISSILE_NEXT,
		MISSILE_RUN,
		FINISH
	} ctrl_state_t;

endpackage

//--- source/scene_render_top.sv
`timescale 1ns/10ps

module scene_render_top
	import scene_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic [NUM_MISSILES-1:0] missile_en,
	input  logic                    credit_return,
	output pixel_t                  pix,
	output logic                    pix_valid,
	output logic                    busy,
	output logic                    done
);

	rect_idx_t rect_idx;
	logic rect_go;
	logic rect_last;
	missile_idx_t missile_idx;
	logic missile_go;
	logic trail_last;
	src_sel_t src_sel;

	// Source handshake
	pixel_t rect_pixel;
	logic rect_valid;
	pixel_t trail_pixel;
	logic trail_valid;
	logic take;

	render_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.missile_en  (missile_en),
		.rect_last   (rect_last),
		.trail_last  (trail_last),
		.rect_idx    (rect_idx),
		.rect_go     (rect_go),
		.missile_idx (missile_idx),
		.missile_go  (missile_go),
		.src_sel     (src_sel),
		.busy        (busy),
		.done        (done)
	);

	rect_scanner u_rect (
		.clk         (clk),
		.rst         (rst),
		.rect_idx    (rect_idx),
		.rect_go     (rect_go),
		.take        (take),
		.pixel       (rect_pixel),
		.pixel_valid (rect_valid),
		.rect_last   (rect_last)
	);

	missile_tracer u_trail (
		.clk         (clk),
		.rst         (rst),
		.missile_idx (missile_idx),
		.missile_go  (missile_go),
		.take        (take),
		.pixel       (trail_pixel),
		.pixel_valid (trail_valid),
		.trail_last  (trail_last)
	);

	pixel_credit_out u_out (
		.clk           (clk),
		.rst           (rst),
		.src_sel       (src_sel),
		.rect_pixel    (rect_pixel),
		.rect_valid    (rect_valid),
		.trail_pixel   (trail_pixel),
		.trail_valid   (trail_valid),
		.credit_return (credit_return),
		.take          (take),
		.pix           (pix),
		.pix_valid     (pix_valid)
	);

endmodule

//--- tb/scene_render_sva.sv
`timescale 1ns/10ps

module scene_render_sva
	import scene_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input credit_t credit,
	input logic    pix_valid,
	input pixel_t  pix
);

	// Count of failed assertions
	int fail_count = 0;

	// Credit handshake
	// ------------------------------
	valid_needs_credit: assert property (@(posedge clk) disable iff (!rst)
		pix_valid |-> (credit != '0))
		else
		begin
			$error("pix_valid asserted with zero credit");
			fail_count++;
		end

	credit_in_range: assert property (@(posedge clk) disable iff (!rst)
		credit <= credit_t'(PIX_CREDITS))
		else
		begin
			$error("credit count above its reset value");
			fail_count++;
		end

	pix_known: assert property (@(posedge clk) disable iff (!rst)
		pix_valid |-> !$isunknown(pix))
		else
		begin
			$error("pix holds X while valid");
			fail_count++;
		end

endmodule

bind pixel_credit_out scene_render_sva sva0 (
	.clk       (clk),
	.rst       (rst),
	.credit    (credit),
	.pix_valid (pix_valid),
	.pix       (pix)
);

//--- tb/scene_stim.txt
// Columns: missile mask, max credit return delay (cycles),
// expected total pixels, expected missile-colour pixels
f 0 15308 68
0 0 152a0 0
5 3 152d4 34
f 7 15308 68

//--- tb/tb_scene_render.sv
`timescale 1ns/10ps

module tb_scene_render
	import scene_pkg::*;
();

	localparam int MAX_TESTS = 8;
	localparam int ROW_PIXELS = 320;
	localparam int RECT_PIXELS = 86688;
	localparam int TRAIL_LEN = 26;

	logic clk;
	logic rst;
	logic start;
	logic [3:0] missile_en;
	logic credit_return;
	pixel_t pix;
	logic pix_valid;
	logic busy;
	logic done;

	logic [31:0] stim_mem [4*MAX_TESTS];
	int num_tests;
	int cycle_limit;
	int cycles;
	int errors;
	int seed = 95;

	// Trail start x and step per missile
	int trail_x0 [4] = '{54, 128, 56, 266};
	int trail_dx [4] = '{1, -2, 4, -1};

	// Sink state
	logic [3:0] cur_mask;
	int max_delay;
	int frame_idx;
	int total_pix;
	int returned;
	int done_count;
	int col_count [8];
	int sink_cycle;
	int last_due;
	int due;
	int ret_delay;
	int due_q [$];
	logic prev_valid;

	// Per-test snapshots
	int base_total;
	int base_done;
	int base_col [8];

	scene_render_top dut0 (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.missile_en    (missile_en),
		.credit_return (credit_return),
		.pix           (pix),
		.pix_valid     (pix_valid),
		.busy          (busy),
		.done          (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "Stopped at first error");
		end
	endtask

	task automatic fail_now(input string msg);
		errors++;
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	// Index of the m-th set bit, or -1 if there is none
	function automatic int nth_enabled(input logic [3:0] mask, input int m);
		int cnt;
		int found;
		cnt = 0;
		found = -1;
		for (int i = 0; i < 4; i++)
		begin
			if (mask[i] && found < 0)
			begin
				if (cnt == m)
					found = i;
				cnt++;
			end
		end
		return found;
	endfunction

	task automatic check_pixel(input pixel_t p);
		int m;
		int k;
		int mi;
		if (frame_idx < ROW_PIXELS)
		begin
			check_value("pix.x", p.x, frame_idx);
			check_value("pix.y", p.y, 0);
			check_value("pix.color", p.color, 0);
		end
		else if (frame_idx >= RECT_PIXELS)
		begin
			m = (frame_idx - RECT_PIXELS) / TRAIL_LEN;
			k = (frame_idx - RECT_PIXELS) % TRAIL_LEN;
			mi = nth_enabled(cur_mask, m);
			if (mi < 0)
				fail_now("Missile pixel found beyond the enabled trails");
			else
			begin
				check_value("pix.x", p.x, (trail_x0[mi] + k * trail_dx[mi]) & 32'h1ff);
				check_value("pix.y", p.y, k * 8);
				check_value("pix.color", p.color, 5);
			end
		end
	endtask

	// Timeout
	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit)
		begin
			$display("Timeout: run went past %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$fatal(1, "Run did not finish");
		end
	end

	// Pixel sink with delayed credit return
	// ------------------------------
	always @(posedge clk)
	begin
		sink_cycle++;
		if (!rst)
		begin
			credit_return <= 1'b0;
			frame_idx = 0;
			prev_valid = 1'b0;
		end
		else
		begin
			if (pix_valid)
			begin
				check_pixel(pix);
				frame_idx++;
				total_pix++;
				col_count[pix.color]++;
				ret_delay = $unsigned($random(seed)) % (max_delay + 1);
				due = sink_cycle + ret_delay;
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
			end
			if (done)
			begin
				check_value("pix_valid before done", prev_valid, 1);
				done_count++;
				frame_idx = 0;
			end
			if (due_q.size() > 0 && due_q[0] <= sink_cycle)
			begin
				void'(due_q.pop_front());
				credit_return <= 1'b1;
				returned++;
			end
			else
			begin
				credit_return <= 1'b0;
			end
			prev_valid = pix_valid;
			if (total_pix - returned > PIX_CREDITS)
				fail_now("Sink holds more pixels than the credits allow");
			if (dut0.u_out.sva0.fail_count != 0)
				fail_now("A credit handshake assertion failed");
		end
	end

	initial
	begin
		rst = 1'b0;
		start = 1'b0;
		missile_en = 4'h0;
		credit_return = 1'b0;
		cur_mask = 4'h0;
		max_delay = 0;
		// Unread words stay far above any mask value
		for (int i = 0; i < 4 * MAX_TESTS; i++)
			stim_mem[i] = 32'hffff_0000 + i;
		$readmemh("tb/scene_stim.txt", stim_mem);
		num_tests = 0;
		cycle_limit = 1000;
		while (num_tests < MAX_TESTS && stim_mem[4*num_tests] <= 32'hf)
		begin
			cycle_limit += stim_mem[4*num_tests+2] * (stim_mem[4*num_tests+1] + 2);
			num_tests++;
		end
		if (num_tests == 0)
			fail_now("No test lines found in the stimulus file");

		repeat (3) @(posedge clk);
		rst <= 1'b1;

		// Idle after reset
		repeat (5)
		begin
			@(posedge clk);
			check_value("pix_valid", pix_valid, 0);
			check_value("busy", busy, 0);
			check_value("done", done, 0);
		end

		for (int t = 0; t < num_tests; t++)
		begin
			cur_mask <= stim_mem[4*t][3:0];
			max_delay <= stim_mem[4*t+1];
			base_total = total_pix;
			base_done = done_count;
			base_col = col_count;
			start <= 1'b1;
			missile_en <= stim_mem[4*t][3:0];
			@(posedge clk);
			start <= 1'b0;
			missile_en <= ~stim_mem[4*t][3:0];
			@(posedge clk);
			check_value("busy", busy, 1);

			// Start while busy must be ignored
			while (total_pix - base_total < 100)
				@(posedge clk);
			start <= 1'b1;
			missile_en <= 4'h0;
			@(posedge clk);
			start <= 1'b0;

			while (done !== 1'b1)
				@(posedge clk);
			// Busy falls in the same cycle as done
			check_value("busy", busy, 0);
			repeat (4) @(posedge clk);
			check_value("busy", busy, 0);
			check_value("done count", done_count - base_done, 1);
			check_value("total pixels", total_pix - base_total, stim_mem[4*t+2]);
			check_value("colour 5 pixels", col_count[5] - base_col[5], stim_mem[4*t+3]);
			check_value("colour 0 pixels", col_count[0] - base_col[0], 76800);
			check_value("colour 7 pixels", col_count[7] - base_col[7], 9600);
			check_value("colour 2 pixels", col_count[2] - base_col[2], 288);
		end

		if (errors == 0 && dut0.u_out.sva0.fail_count == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("TEST FAIL");
			$fatal(1, "Errors found");
		end
	end

endmodule
